//--- Makefile
VERILATOR ?= verilator
TOP ?= cpuBench
FILELIST ?= vlog.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert
RUN_ARGS ?= +verilator+error+limit+100
PASS_TEXT ?= Everything OK

SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) | tee $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- bench/cpuBench.sv
`timescale 1ns/100ps

module cpuBench;

    localparam int clockPeriod = 4;
    localparam int progLen = 18;
    localparam int progCount = 5;
    // loading and register sweeps take most of the time
    localparam int watchdogCycles = progCount * progLen * 4
                                    + progCount * (cpuPkg::imemWords + cpuPkg::regCount) * 3
                                    + 1000;
    localparam logic [8:0][5:0] functList = {cpuPkg::fnAdd, cpuPkg::fnAddu, cpuPkg::fnSub,
        cpuPkg::fnSubu, cpuPkg::fnAnd, cpuPkg::fnOr, cpuPkg::fnXor, cpuPkg::fnNor, cpuPkg::fnSlt};
    localparam logic [3:0][5:0] immOpList = {cpuPkg::opAddi, cpuPkg::opAddiu, cpuPkg::opAndi,
        cpuPkg::opOri};

    logic clock;
    logic reset;
    logic psel;
    logic penable;
    logic pwrite;
    cpuPkg::apbAddr_t paddr;
    cpuPkg::word_t pwdata;
    cpuPkg::word_t prdata;
    logic pready;
    logic pslverr;

    integer seed = 32'ha48e;
    int checks = 0;
    int errors = 0;
    int testStartErrors = 0;
    int testCount = 0;
    cpuPkg::word_t prog [cpuPkg::imemWords];
    cpuPkg::word_t modelRegs [cpuPkg::regCount] = '{default: '0};
    cpuPkg::word_t modelMem [cpuPkg::dmemWords] = '{default: '0};

    pipelineCpu dut
    (
        .clock(clock),
        .i_reset(reset),
        .i_psel(psel),
        .i_penable(penable),
        .i_pwrite(pwrite),
        .i_paddr(paddr),
        .i_pwdata(pwdata),
        .o_prdata(prdata),
        .o_pready(pready),
        .o_pslverr(pslverr)
    );

    initial
    begin
        clock = 1'b0;
        forever #(clockPeriod / 2) clock = ~clock;
    end

    function automatic int rnd(int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    function automatic cpuPkg::word_t itypeWord(logic [5:0] op, cpuPkg::regAddr_t rs,
                                                cpuPkg::regAddr_t rt, logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // eight words spread across data memory
    // high byte lands outside the 256-byte window and wraps back
    function automatic logic [15:0] memOffset();
        return {(rnd(2) == 0) ? 8'(rnd(256)) : 8'h00, 6'(9 * rnd(8)), 2'b00};
    endfunction

    // dropped branches and shifts
    function automatic cpuPkg::word_t unsupportedWord();
        cpuPkg::word_t w;
        w = $random(seed);
        if (rnd(2) == 0)
            return {6'h04, w[25:0]};
        return {cpuPkg::opRtype, w[25:6], 3'b000, w[2:0]};
    endfunction

    task automatic buildProgram(input int mode);
        cpuPkg::regAddr_t last;
        cpuPkg::regAddr_t rs;
        cpuPkg::regAddr_t rt;
        cpuPkg::regAddr_t rd;
        logic [3:0] k;
        logic [1:0] m;
        logic loadBefore;
        int pick;
        last = 5'd1;
        loadBefore = 1'b0;
        for (int i = 0; i < progLen; i++)
        begin
            // reuse the last destination half the time and always after a load
            rs = (loadBefore || rnd(2) == 0) ? last : cpuPkg::regAddr_t'(rnd(32));
            rt = (rnd(2) == 0) ? last : cpuPkg::regAddr_t'(rnd(32));
            rd = cpuPkg::regAddr_t'(1 + rnd(31));
            if (mode == 2 && rnd(3) == 0)
                rd = '0;
            k = 4'(rnd(9));
            m = 2'(rnd(4));
            pick = rnd(10);
            if (mode == 1 && pick < 3)
                prog[i] = itypeWord(cpuPkg::opSw, 5'd0, rt, memOffset());
            else if (mode == 1 && pick < 6)
                prog[i] = itypeWord(cpuPkg::opLw, 5'd0, rd, memOffset());
            else if (mode == 2 && pick < 3)
                prog[i] = unsupportedWord();
            else if (rnd(2) == 0)
                prog[i] = {cpuPkg::opRtype, rs, rt, rd, 5'b0, functList[k]};
            else
                prog[i] = itypeWord(immOpList[m], rs, rd, 16'(rnd(65536)));
            loadBefore = (mode == 1 && pick >= 3 && pick < 6);
            last = rd;
        end
    endtask

    task automatic setReg(input cpuPkg::regAddr_t r, input cpuPkg::word_t value);
        if (r != '0)
            modelRegs[r] = value;
    endtask

    // one instruction at a time, in program order
    task automatic modelProgram();
        cpuPkg::word_t w;
        cpuPkg::word_t a;
        cpuPkg::word_t b;
        cpuPkg::word_t sext;
        cpuPkg::word_t zext;
        cpuPkg::word_t sum;
        for (int i = 0; i < progLen; i++)
        begin
            w = prog[i];
            a = modelRegs[w[25:21]];
            b = modelRegs[w[20:16]];
            sext = {{16{w[15]}}, w[15:0]};
            zext = {16'h0000, w[15:0]};
            sum = a + sext;
            case (w[31:26])
                cpuPkg::opRtype:
                    case (w[5:0])
                        cpuPkg::fnAdd, cpuPkg::fnAddu: setReg(w[15:11], a + b);
                        cpuPkg::fnSub, cpuPkg::fnSubu: setReg(w[15:11], a - b);
                        cpuPkg::fnAnd: setReg(w[15:11], a & b);
                        cpuPkg::fnOr: setReg(w[15:11], a | b);
                        cpuPkg::fnXor: setReg(w[15:11], a ^ b);
                        cpuPkg::fnNor: setReg(w[15:11], ~(a | b));
                        cpuPkg::fnSlt: setReg(w[15:11], ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
                        default: ;
                    endcase
                cpuPkg::opAddi, cpuPkg::opAddiu: setReg(w[20:16], sum);
                cpuPkg::opAndi: setReg(w[20:16], a & zext);
                cpuPkg::opOri: setReg(w[20:16], a | zext);
                cpuPkg::opLw: setReg(w[20:16], modelMem[sum[7:2]]);
                cpuPkg::opSw: modelMem[sum[7:2]] = b;
                default: ;
            endcase
        end
    endtask

    task automatic checkWord(input string name, input cpuPkg::word_t got,
                             input cpuPkg::word_t want);
        checks++;
        if (got !== want)
        begin
            errors++;
            $display("ERROR at %0t: %s is %h, expected %h", $time, name, got, want);
        end
    endtask

    task automatic checkError(input string name, input logic got, input logic want);
        checks++;
        if (got !== want)
        begin
            errors++;
            $display("ERROR at %0t: %s is %b, expected %b", $time, name, got, want);
        end
    endtask

    // setup and access cycles with a sample mid access
    task automatic apbTransfer(input logic write, input cpuPkg::apbAddr_t addr,
                               input cpuPkg::word_t wdata, output cpuPkg::word_t rdata,
                               output logic err);
        @(posedge clock);
        psel <= 1'b1;
        penable <= 1'b0;
        pwrite <= write;
        paddr <= addr;
        pwdata <= wdata;
        @(posedge clock);
        penable <= 1'b1;
        @(negedge clock);
        rdata = prdata;
        err = pslverr;
        @(posedge clock);
        psel <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic apbWrite(input cpuPkg::apbAddr_t addr, input cpuPkg::word_t data,
                            output logic err);
        cpuPkg::word_t ignored;
        apbTransfer(1'b1, addr, data, ignored, err);
    endtask

    task automatic apbRead(input cpuPkg::apbAddr_t addr, output cpuPkg::word_t data,
                           output logic err);
        apbTransfer(1'b0, addr, '0, data, err);
    endtask

    task automatic checkAllRegs();
        cpuPkg::word_t data;
        logic err;
        for (int r = 0; r < cpuPkg::regCount; r++)
        begin
            apbRead(cpuPkg::apbRegBase + 12'(4 * r), data, err);
            checkWord($sformatf("o_prdata (r%0d)", r), data, modelRegs[r]);
            checkError("o_pslverr", err, 1'b0);
        end
    endtask

    task automatic runProgram();
        logic err;
        for (int i = 0; i < cpuPkg::imemWords; i++)
        begin
            apbWrite(cpuPkg::apbImemBase + 12'(4 * i), (i < progLen) ? prog[i] : '0, err);
            checkError("o_pslverr", err, 1'b0);
        end
        apbWrite(cpuPkg::apbControl, 32'd1, err);
        checkError("o_pslverr", err, 1'b0);
        repeat (2 * progLen + 20) @(posedge clock);
        apbWrite(cpuPkg::apbControl, 32'd0, err);
        checkError("o_pslverr", err, 1'b0);
        modelProgram();
        checkAllRegs();
    endtask

    task automatic errorAccesses();
        cpuPkg::word_t data;
        logic err;
        apbRead(12'h180, data, err);
        checkError("o_pslverr (read 0x180)", err, 1'b1);
        apbWrite(12'h204, 32'd1, err);
        checkError("o_pslverr (write 0x204)", err, 1'b1);
        apbRead(12'hffc, data, err);
        checkError("o_pslverr (read 0xffc)", err, 1'b1);
        apbRead(cpuPkg::apbImemBase + 12'h010, data, err);
        checkError("o_pslverr (read imem)", err, 1'b1);
        apbWrite(cpuPkg::apbRegBase + 12'h00c, 32'h5a5a1234, err);
        checkError("o_pslverr (write r3)", err, 1'b1);
        // a stray write to 0x204 would have started the core
        apbRead(cpuPkg::apbControl, data, err);
        checkWord("o_prdata (control)", data, '0);
        checkError("o_pslverr (read control)", err, 1'b0);
        checkAllRegs();
    endtask

    task automatic finishTest(input string name);
        $display("test %0d %s: %s, %0d errors", testCount + 1, name,
                 (errors == testStartErrors) ? "passed" : "failed", errors - testStartErrors);
        testStartErrors = errors;
        testCount++;
    endtask

    initial
    begin
        #(watchdogCycles * clockPeriod);
        $display("watchdog expired after %0d cycles, the tests did not finish", watchdogCycles);
        $display("Something failed");
        $finish;
    end

    initial
    begin
        reset = 1'b1;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        repeat (4) @(posedge clock);
        reset <= 1'b0;

        checkAllRegs();
        errorAccesses();
        finishTest("reset state");
        buildProgram(0);
        runProgram();
        finishTest("dependent ALU chains");
        buildProgram(1);
        runProgram();
        finishTest("loads, stores and load-use");
        buildProgram(2);
        runProgram();
        finishTest("r0 writes and unsupported words");
        errorAccesses();
        finishTest("APB error responses");
        buildProgram(0);
        runProgram();
        buildProgram(1);
        runProgram();
        finishTest("restart with carried registers");

        errors += dut.protocolCheck.failures;
        $display("%0d tests, %0d checks, %0d errors, %0d assertion failures", testCount, checks,
                 errors, dut.protocolCheck.failures);
        if (errors == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

endmodule

//--- bench/cpuChecker.sv
`timescale 1ns/100ps

module cpuChecker
(
    input logic clock,
    input logic i_reset,
    input logic i_psel,
    input logic i_penable,
    input logic i_pready,
    input logic i_pslverr,
    input logic i_stall
);

    int failures = 0;

    // no wait states, ever
    readyHigh: assert property (@(posedge clock) i_pready)
    else
    begin
        failures++;
        $error("o_pready dropped low");
    end

    errorInAccess: assert property (@(posedge clock) disable iff (i_reset)
        i_pslverr |-> (i_psel && i_penable))
    else
    begin
        failures++;
        $error("o_pslverr high outside an access cycle");
    end

    // the bubble clears the load from execute
    singleStall: assert property (@(posedge clock) disable iff (i_reset) i_stall |=> !i_stall)
    else
    begin
        failures++;
        $error("stall held for two cycles");
    end

endmodule

bind pipelineCpu cpuChecker protocolCheck (.clock(clock), .i_reset(i_reset), .i_psel(i_psel),
    .i_penable(i_penable), .i_pready(o_pready), .i_pslverr(o_pslverr), .i_stall(stall));

//--- rtl/cpuPkg.sv
package cpuPkg;

    localparam int dataWidth = 32;
    localparam int regCount = 32;
    localparam int imemWords = 64;
    localparam int dmemWords = 64;

    typedef logic [dataWidth-1:0] word_t;
    typedef logic [4:0] regAddr_t;
    // word index from byte address bits 7:2
    typedef logic [5:0] memAddr_t;
    typedef logic [11:0] apbAddr_t;

    localparam logic [5:0] opRtype = 6'h00;
    localparam logic [5:0] opAddi = 6'h08;
    localparam logic [5:0] opAddiu = 6'h09;
    localparam logic [5:0] opAndi = 6'h0c;
    localparam logic [5:0] opOri = 6'h0d;
    localparam logic [5:0] opLw = 6'h23;
    localparam logic [5:0] opSw = 6'h2b;

    localparam logic [5:0] fnAdd = 6'h20;
    localparam logic [5:0] fnAddu = 6'h21;
    localparam logic [5:0] fnSub = 6'h22;
    localparam logic [5:0] fnSubu = 6'h23;
    localparam logic [5:0] fnAnd = 6'h24;
    localparam logic [5:0] fnOr = 6'h25;
    localparam logic [5:0] fnXor = 6'h26;
    localparam logic [5:0] fnNor = 6'h27;
    localparam logic [5:0] fnSlt = 6'h2a;

    typedef enum logic [2:0] {aluAdd, aluSub, aluAnd, aluOr, aluXor, aluNor, aluSlt} aluOp_t;
    typedef enum logic [1:0] {fwdNone, fwdMemory, fwdWrite} forwardSel_t;

    typedef struct packed {
        logic valid;
        word_t instr;
    } fetchToDecode_t;

    typedef struct packed {
        logic valid;
        logic regWrite;
        logic memRead;
        logic memWrite;
        logic aluSrc;
        aluOp_t aluOp;
        regAddr_t rs;
        regAddr_t rt;
        regAddr_t dest;
        word_t rsData;
        word_t rtData;
        word_t imm;
    } decodeToExecute_t;

    typedef struct packed {
        logic valid;
        logic regWrite;
        logic memRead;
        logic memWrite;
        regAddr_t dest;
        word_t aluResult;
        word_t storeData;
    } executeToMemory_t;

    typedef struct packed {
        logic write;
        regAddr_t dest;
        word_t result;
    } writeBack_t;

    // host windows
    localparam apbAddr_t apbImemBase = 12'h000;
    localparam apbAddr_t apbRegBase = 12'h100;
    localparam apbAddr_t apbControl = 12'h200;

    typedef struct packed {
        logic enable;
        memAddr_t addr;
        word_t data;
    } hostImemWrite_t;

endpackage

//--- rtl/decodeStage.sv
`timescale 1ns/100ps

module decodeStage
(
    input  logic                      clock,
    input  logic                      i_reset,
    input  cpuPkg::fetchToDecode_t    i_fromFetch,
    input  logic                      i_stall,
    input  cpuPkg::writeBack_t        i_writeBack,
    input  cpuPkg::regAddr_t          i_hostReadAddr,
    output cpuPkg::decodeToExecute_t  o_toExecute,
    output cpuPkg::word_t             o_hostReadData,
    output cpuPkg::regAddr_t          o_rs,
    output cpuPkg::regAddr_t          o_rt
);

    cpuPkg::word_t regs [cpuPkg::regCount];
    cpuPkg::word_t instr;
    logic [5:0] opcode;
    logic [5:0] funct;
    cpuPkg::regAddr_t rd;
    logic regWrite;
    logic memRead;
    logic memWrite;
    logic aluSrc;
    logic zeroExtend;
    cpuPkg::aluOp_t aluOp;
    cpuPkg::regAddr_t dest;
    cpuPkg::decodeToExecute_t nextEntry;

    // same-cycle write-back wins over the stored value
    function automatic cpuPkg::word_t bypass(cpuPkg::regAddr_t addr, cpuPkg::word_t stored,
                                             cpuPkg::writeBack_t wb);
        if (wb.write && wb.dest == addr && addr != '0)
            return wb.result;
        return stored;
    endfunction

    assign instr = i_fromFetch.instr;
    assign opcode = instr[31:26];
    assign funct = instr[5:0];
    assign o_rs = instr[25:21];
    assign o_rt = instr[20:16];
    assign rd = instr[15:11];

    always_comb
    begin
        regWrite = 1'b0;
        memRead = 1'b0;
        memWrite = 1'b0;
        aluSrc = 1'b1;
        zeroExtend = 1'b0;
        aluOp = cpuPkg::aluAdd;
        dest = o_rt;
        case (opcode)
            cpuPkg::opRtype:
            begin
                aluSrc = 1'b0;
                dest = rd;
                regWrite = 1'b1;
                case (funct)
                    cpuPkg::fnAdd, cpuPkg::fnAddu: aluOp = cpuPkg::aluAdd;
                    cpuPkg::fnSub, cpuPkg::fnSubu: aluOp = cpuPkg::aluSub;
                    cpuPkg::fnAnd: aluOp = cpuPkg::aluAnd;
                    cpuPkg::fnOr: aluOp = cpuPkg::aluOr;
                    cpuPkg::fnXor: aluOp = cpuPkg::aluXor;
                    cpuPkg::fnNor: aluOp = cpuPkg::aluNor;
                    cpuPkg::fnSlt: aluOp = cpuPkg::aluSlt;
                    // unknown function acts as a no-op
                    default: regWrite = 1'b0;
                endcase
            end
            cpuPkg::opAddi, cpuPkg::opAddiu: regWrite = 1'b1;
            cpuPkg::opAndi:
            begin
                regWrite = 1'b1;
                zeroExtend = 1'b1;
                aluOp = cpuPkg::aluAnd;
            end
            cpuPkg::opOri:
            begin
                regWrite = 1'b1;
                zeroExtend = 1'b1;
                aluOp = cpuPkg::aluOr;
            end
            cpuPkg::opLw:
            begin
                regWrite = 1'b1;
                memRead = 1'b1;
            end
            cpuPkg::opSw: memWrite = 1'b1;
            default: ;
        endcase
    end

    always_comb
    begin
        nextEntry.valid = i_fromFetch.valid;
        nextEntry.regWrite = i_fromFetch.valid & regWrite;
        nextEntry.memRead = i_fromFetch.valid & memRead;
        nextEntry.memWrite = i_fromFetch.valid & memWrite;
        nextEntry.aluSrc = aluSrc;
        nextEntry.aluOp = aluOp;
        nextEntry.rs = o_rs;
        nextEntry.rt = o_rt;
        nextEntry.dest = dest;
        nextEntry.rsData = bypass(o_rs, regs[o_rs], i_writeBack);
        nextEntry.rtData = bypass(o_rt, regs[o_rt], i_writeBack);
        nextEntry.imm = zeroExtend ? {16'b0, instr[15:0]} : {{16{instr[15]}}, instr[15:0]};
    end

    assign o_hostReadData = bypass(i_hostReadAddr, regs[i_hostReadAddr], i_writeBack);

    // r0 is never written
    always_ff @(posedge clock)
    begin
        if (i_reset)
        begin
            for (int i = 0; i < cpuPkg::regCount; i++)
                regs[i] <= '0;
        end
        else if (i_writeBack.write && i_writeBack.dest != '0)
            regs[i_writeBack.dest] <= i_writeBack.result;
    end

    // bubble into execute on a load-use stall
    always_ff @(posedge clock)
    begin
        if (i_reset || i_stall)
            o_toExecute <= '0;
        else
            o_toExecute <= nextEntry;
    end

endmodule

//--- rtl/executeStage.sv
`timescale 1ns/100ps

module executeStage
(
    input  logic                      clock,
    input  logic                      i_reset,
    input  cpuPkg::decodeToExecute_t  i_fromDecode,
    input  cpuPkg::forwardSel_t       i_forwardA,
    input  cpuPkg::forwardSel_t       i_forwardB,
    input  cpuPkg::word_t             i_memoryResult,
    input  cpuPkg::writeBack_t        i_writeBack,
    output cpuPkg::executeToMemory_t  o_toMemory
);

    cpuPkg::word_t operandA;
    cpuPkg::word_t operandB;
    cpuPkg::word_t storeData;
    cpuPkg::word_t aluResult;
    cpuPkg::executeToMemory_t nextEntry;

    function automatic cpuPkg::word_t forward(cpuPkg::forwardSel_t sel,
                                              cpuPkg::word_t stageValue,
                                              cpuPkg::word_t memoryValue,
                                              cpuPkg::word_t writeValue);
        case (sel)
            cpuPkg::fwdMemory: return memoryValue;
            cpuPkg::fwdWrite: return writeValue;
            default: return stageValue;
        endcase
    endfunction

    assign operandA = forward(i_forwardA, i_fromDecode.rsData, i_memoryResult,
                              i_writeBack.result);
    assign storeData = forward(i_forwardB, i_fromDecode.rtData, i_memoryResult,
                               i_writeBack.result);
    assign operandB = i_fromDecode.aluSrc ? i_fromDecode.imm : storeData;

    // arithmetic wraps, slt is signed
    always_comb
    begin
        case (i_fromDecode.aluOp)
            cpuPkg::aluSub: aluResult = operandA - operandB;
            cpuPkg::aluAnd: aluResult = operandA & operandB;
            cpuPkg::aluOr: aluResult = operandA | operandB;
            cpuPkg::aluXor: aluResult = operandA ^ operandB;
            cpuPkg::aluNor: aluResult = ~(operandA | operandB);
            cpuPkg::aluSlt: aluResult = cpuPkg::word_t'($signed(operandA) < $signed(operandB));
            default: aluResult = operandA + operandB;
        endcase
    end

    always_comb
    begin
        nextEntry.valid = i_fromDecode.valid;
        nextEntry.regWrite = i_fromDecode.regWrite;
        nextEntry.memRead = i_fromDecode.memRead;
        nextEntry.memWrite = i_fromDecode.memWrite;
        nextEntry.dest = i_fromDecode.dest;
        nextEntry.aluResult = aluResult;
        nextEntry.storeData = storeData;
    end

    always_ff @(posedge clock)
    begin
        if (i_reset)
            o_toMemory <= '0;
        else
            o_toMemory <= nextEntry;
    end

endmodule

//--- rtl/fetchStage.sv
`timescale 1ns/100ps

module fetchStage
(
    input  logic                    clock,
    input  logic                    i_reset,
    input  logic                    i_run,
    input  logic                    i_stall,
    input  cpuPkg::hostImemWrite_t  i_imemWrite,
    output cpuPkg::fetchToDecode_t  o_toDecode
);

    cpuPkg::word_t imem [cpuPkg::imemWords];
    cpuPkg::word_t pc;
    cpuPkg::memAddr_t fetchAddr;

    assign fetchAddr = pc[7:2];

    // host loads the program
    always_ff @(posedge clock)
    begin
        if (i_imemWrite.enable)
            imem[i_imemWrite.addr] <= i_imemWrite.data;
    end

    // pc parks at zero while the core is stopped
    always_ff @(posedge clock)
    begin
        if (i_reset)
            pc <= '0;
        else if (!i_run)
            pc <= '0;
        else if (!i_stall)
            pc <= pc + 32'd4;
    end

    always_ff @(posedge clock)
    begin
        if (i_reset)
            o_toDecode.valid <= 1'b0;
        else if (!i_stall)
        begin
            o_toDecode.valid <= i_run;
            o_toDecode.instr <= imem[fetchAddr];
        end
    end

endmodule

//--- rtl/hazardUnit.sv
`timescale 1ns/100ps

module hazardUnit
(
    input  cpuPkg::regAddr_t     i_decodeRs,
    input  cpuPkg::regAddr_t     i_decodeRt,
    input  cpuPkg::regAddr_t     i_executeRs,
    input  cpuPkg::regAddr_t     i_executeRt,
    input  logic                 i_executeLoad,
    input  cpuPkg::regAddr_t     i_executeDest,
    input  logic                 i_memoryWrite,
    input  cpuPkg::regAddr_t     i_memoryDest,
    input  logic                 i_writeWrite,
    input  cpuPkg::regAddr_t     i_writeDest,
    output cpuPkg::forwardSel_t  o_forwardA,
    output cpuPkg::forwardSel_t  o_forwardB,
    output logic                 o_stall
);

    // newest producer first
    function automatic cpuPkg::forwardSel_t select(cpuPkg::regAddr_t src);
        if (src == '0)
            return cpuPkg::fwdNone;
        if (i_memoryWrite && i_memoryDest == src)
            return cpuPkg::fwdMemory;
        if (i_writeWrite && i_writeDest == src)
            return cpuPkg::fwdWrite;
        return cpuPkg::fwdNone;
    endfunction

    always_comb
    begin
        o_forwardA = select(i_executeRs);
        o_forwardB = select(i_executeRt);
    end

    // load data only exists after the memory stage
    assign o_stall = i_executeLoad && i_executeDest != '0 &&
                     (i_executeDest == i_decodeRs || i_executeDest == i_decodeRt);

endmodule

//--- rtl/hostPort.sv
`timescale 1ns/100ps

module hostPort
(
    input  logic                    clock,
    input  logic                    i_reset,
    input  logic                    i_psel,
    input  logic                    i_penable,
    input  logic                    i_pwrite,
    input  cpuPkg::apbAddr_t        i_paddr,
    input  cpuPkg::word_t           i_pwdata,
    input  cpuPkg::word_t           i_regReadData,
    output cpuPkg::word_t           o_prdata,
    output logic                    o_pready,
    output logic                    o_pslverr,
    output logic                    o_run,
    output cpuPkg::hostImemWrite_t  o_imemWrite,
    output cpuPkg::regAddr_t        o_regReadAddr
);

    logic access;
    logic imemHit;
    logic regHit;
    logic ctrlHit;

    assign access = i_psel && i_penable;
    assign imemHit = i_paddr[11:8] == cpuPkg::apbImemBase[11:8];
    assign regHit = i_paddr[11:7] == cpuPkg::apbRegBase[11:7];
    assign ctrlHit = i_paddr[11:2] == cpuPkg::apbControl[11:2];

    // no wait states
    assign o_pready = 1'b1;
    assign o_pslverr = access && (!(imemHit || regHit || ctrlHit) ||
                                  (imemHit && !i_pwrite) || (regHit && i_pwrite));
    assign o_regReadAddr = i_paddr[6:2];

    always_comb
    begin
        o_imemWrite.enable = access && i_pwrite && imemHit;
        o_imemWrite.addr = i_paddr[7:2];
        o_imemWrite.data = i_pwdata;
        o_prdata = '0;
        if (!i_pwrite && regHit)
            o_prdata = i_regReadData;
        else if (!i_pwrite && ctrlHit)
            o_prdata = cpuPkg::word_t'(o_run);
    end

    always_ff @(posedge clock)
    begin
        if (i_reset)
            o_run <= 1'b0;
        else if (access && i_pwrite && ctrlHit)
            o_run <= i_pwdata[0];
    end

endmodule

//--- rtl/memoryStage.sv
`timescale 1ns/100ps

module memoryStage
(
    input  logic                      clock,
    input  logic                      i_reset,
    input  cpuPkg::executeToMemory_t  i_fromExecute,
    output cpuPkg::writeBack_t        o_writeBack
);

    cpuPkg::word_t dmem [cpuPkg::dmemWords];
    cpuPkg::memAddr_t wordAddr;

    // upper address bits ignored, so accesses wrap
    assign wordAddr = i_fromExecute.aluResult[7:2];

    always_ff @(posedge clock)
    begin
        if (i_reset)
        begin
            for (int i = 0; i < cpuPkg::dmemWords; i++)
                dmem[i] <= '0;
        end
        else if (i_fromExecute.memWrite)
            dmem[wordAddr] <= i_fromExecute.storeData;
    end

    always_ff @(posedge clock)
    begin
        if (i_reset)
            o_writeBack <= '0;
        else
        begin
            o_writeBack.write <= i_fromExecute.regWrite;
            o_writeBack.dest <= i_fromExecute.dest;
            o_writeBack.result <= i_fromExecute.memRead ? dmem[wordAddr]
                                                        : i_fromExecute.aluResult;
        end
    end

endmodule

//--- rtl/pipelineCpu.sv
`timescale 1ns/100ps

module pipelineCpu
(
    input  logic              clock,
    input  logic              i_reset,
    input  logic              i_psel,
    input  logic              i_penable,
    input  logic              i_pwrite,
    input  cpuPkg::apbAddr_t  i_paddr,
    input  cpuPkg::word_t     i_pwdata,
    output cpuPkg::word_t     o_prdata,
    output logic              o_pready,
    output logic              o_pslverr
);

    logic run;
    logic stall;
    cpuPkg::hostImemWrite_t imemWrite;
    cpuPkg::regAddr_t regReadAddr;
    cpuPkg::word_t regReadData;
    cpuPkg::regAddr_t decodeRs;
    cpuPkg::regAddr_t decodeRt;
    cpuPkg::forwardSel_t forwardA;
    cpuPkg::forwardSel_t forwardB;
    cpuPkg::fetchToDecode_t fetchToDecode;
    cpuPkg::decodeToExecute_t decodeToExecute;
    cpuPkg::executeToMemory_t executeToMemory;
    cpuPkg::writeBack_t writeBack;

    hostPort host (.clock, .i_reset, .i_psel, .i_penable, .i_pwrite, .i_paddr, .i_pwdata,
        .i_regReadData(regReadData), .o_prdata, .o_pready, .o_pslverr, .o_run(run),
        .o_imemWrite(imemWrite), .o_regReadAddr(regReadAddr));

    fetchStage fetch (.clock, .i_reset, .i_run(run), .i_stall(stall),
        .i_imemWrite(imemWrite), .o_toDecode(fetchToDecode));

    decodeStage decode (.clock, .i_reset, .i_fromFetch(fetchToDecode), .i_stall(stall),
        .i_writeBack(writeBack), .i_hostReadAddr(regReadAddr), .o_toExecute(decodeToExecute),
        .o_hostReadData(regReadData), .o_rs(decodeRs), .o_rt(decodeRt));

    executeStage execute (.clock, .i_reset, .i_fromDecode(decodeToExecute),
        .i_forwardA(forwardA), .i_forwardB(forwardB),
        .i_memoryResult(executeToMemory.aluResult), .i_writeBack(writeBack),
        .o_toMemory(executeToMemory));

    memoryStage memory (.clock, .i_reset, .i_fromExecute(executeToMemory),
        .o_writeBack(writeBack));

    hazardUnit hazard (.i_decodeRs(decodeRs), .i_decodeRt(decodeRt),
        .i_executeRs(decodeToExecute.rs), .i_executeRt(decodeToExecute.rt),
        .i_executeLoad(decodeToExecute.memRead), .i_executeDest(decodeToExecute.dest),
        .i_memoryWrite(executeToMemory.regWrite), .i_memoryDest(executeToMemory.dest),
        .i_writeWrite(writeBack.write), .i_writeDest(writeBack.dest),
        .o_forwardA(forwardA), .o_forwardB(forwardB), .o_stall(stall));

endmodule

//--- vlog.f
rtl/cpuPkg.sv
rtl/hazardUnit.sv
rtl/fetchStage.sv
rtl/decodeStage.sv
rtl/executeStage.sv
rtl/memoryStage.sv
rtl/hostPort.sv
rtl/pipelineCpu.sv
bench/cpuChecker.sv
bench/cpuBench.sv
